/* snowball_cache.f */
rtl/cache_pkg.sv
rtl/lookup_if.sv
rtl/cache_ram.sv
rtl/cache_lookup.sv
rtl/refill_timer.sv
rtl/cache_ctrl_fsm.sv
rtl/snowball_cache.sv
sim/clk_gen.sv
sim/snowball_cache_sva.sv
sim/snowball_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# the exit status is the simulator's, a $fatal makes it nonzero
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
  --top-module snowball_cache_tb \
  -f snowball_cache.f \
  -o snowball_cache_sim \
  && ./obj_dir/snowball_cache_sim \
  || { echo "simulation build or run failed" >&2; exit 1; }

/* sim/snowball_cache_tb.sv */
`default_nettype none

module snowball_cache_tb;

  localparam int          WATCHDOG      = 64;
  localparam int unsigned TIMEOUT_LIMIT = 50 * (WATCHDOG + 10) + 300;   // requests, worst txn, sweep

  typedef struct packed {
    logic [31:0] data;
    logic        fault;
    logic        error;
    logic        mem;     // a memory transaction is expected
    logic [31:0] count;   // memory transactions so far
    logic [31:0] acc;     // cycle of the accepting edge
  } exp_t;

  logic        CPU_CLK;
  logic        RST_CPU;
  logic        cpu_valid;
  logic        cpu_ready;
  logic [31:0] cpu_addr;
  logic        cpu_we;
  logic        cpu_tlb_we;
  logic        cpu_force_miss;
  logic [31:0] cpu_wdata;
  logic        vmem_act;
  logic        rsp_valid;
  logic [31:0] rsp_data;
  logic        rsp_fault;
  logic        rsp_error;
  logic        mem_valid;
  logic        mem_ready;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;

  int unsigned cycle     = 0;
  int unsigned sent      = 0;
  int unsigned rsp_seen  = 0;
  int unsigned mem_count = 0;
  int unsigned ref_count = 0;
  logic [31:0] stim_state = 32'd56;
  logic [31:0] mem_state  = 32'd56;

  exp_t        exp_q [$];
  string       name_q [$];
  logic [31:0] mem_model [logic [31:0]];
  // reference shadows
  logic [31:0] ref_mem [logic [31:0]];
  bit          ref_valid [0:255];
  logic [23:0] ref_tag [0:255];
  logic [31:0] ref_data [0:255];
  logic [31:0] ref_tlb [0:255];   // ppage upper, vtag lower

  clk_gen clk_gen_i (
    .CPU_CLK (CPU_CLK),
    .RST_CPU (RST_CPU)
  );

  snowball_cache #(
    .TIMEOUT_CYCLES (WATCHDOG)
  ) snowball_cache_i (.*);

  bind snowball_cache snowball_cache_sva snowball_cache_sva_i (
    .CPU_CLK   (CPU_CLK),
    .RST_CPU   (RST_CPU),
    .cpu_valid (cpu_valid),
    .cpu_ready (cpu_ready),
    .rsp_valid (rsp_valid),
    .rsp_fault (rsp_fault),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

  function automatic logic [31:0] lcg(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_state = lcg(stim_state);
    return stim_state;
  endfunction

  function automatic int pick_delay();   // 1 to 3 cycles
    mem_state = lcg(mem_state);
    return 1 + int'(mem_state[23:16] % 8'd3);
  endfunction

  // initial memory contents, a function of the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return lcg(a ^ 32'h2545_f491);
  endfunction

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic exp_t predict(input logic we, input logic tlb_we, input logic fm,
                                   input logic vm, input logic [31:0] addr,
                                   input logic [31:0] wd);
    exp_t        e;
    logic [31:0] pa;
    logic [31:0] te;
    logic [7:0]  li;
    e  = '0;
    pa = addr;
    li = addr[7:0];
    te = ref_tlb[addr[15:8]];
    if (vm)
    begin
      pa[31:16] = te[31:16];
      e.fault   = (te[15:0] != addr[31:16]);
    end
    if (tlb_we)
    begin
      ref_tlb[addr[15:8]] = wd;
      e.fault = 1'b0;   // tlb write wins over a fault
      e.data  = wd;
    end
    else if (e.fault)
      e.data = '0;
    else if (!we && !fm && ref_valid[li] && ref_tag[li] == pa[31:8])
      e.data = ref_data[li];
    else
    begin
      e.mem = 1'b1;
      ref_count++;
      if (pa[31:30] == 2'b10)
        e.error = 1'b1;   // watchdog, line untouched
      else
      begin
        if (we)
          ref_mem[pa] = wd;
        else if (!ref_mem.exists(pa))
          ref_mem[pa] = fill_word(pa);
        e.data        = ref_mem[pa];
        ref_valid[li] = 1'b1;
        ref_tag[li]   = pa[31:8];
        ref_data[li]  = e.data;
      end
    end
    e.count = ref_count;
    return e;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (expv !== actv)
    begin
      $display("ERROR %s: expected %h, actual %h", name, expv, actv);
      abort_run("a response did not match the reference model");
    end
  endtask

  task automatic wait_cycle();
    @(posedge CPU_CLK);
    #1;
  endtask

  // one request, returns once its response has been compared
  task automatic send(input string name, input logic we, input logic tlb_we, input logic fm,
                      input logic vm, input logic [31:0] addr, input logic [31:0] wd);
    exp_t e;
    e              = predict(we, tlb_we, fm, vm, addr, wd);
    cpu_addr       = addr;
    cpu_we         = we;
    cpu_tlb_we     = tlb_we;
    cpu_force_miss = fm;
    vmem_act       = vm;
    cpu_wdata      = wd;
    cpu_valid      = 1'b1;
    while (!cpu_ready)
      wait_cycle();
    wait_cycle();   // accepting edge behind us
    cpu_valid = 1'b0;
    e.acc     = cycle;
    exp_q.push_back(e);
    name_q.push_back(name);
    sent++;
    while (rsp_seen != sent)
      wait_cycle();
  endtask

  // --------------------------------------------------
  // memory model
  // --------------------------------------------------
  initial
  begin : memory_model
    logic [31:0] a;
    logic [31:0] d;
    logic        w;
    mem_ready  = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    forever
    begin
      wait_cycle();
      mem_ready  = 1'b0;
      mem_rvalid = 1'b0;
      if (mem_valid)
      begin
        a = mem_addr;
        w = mem_we;
        d = mem_wdata;
        repeat (pick_delay())
          wait_cycle();
        mem_ready = 1'b1;
        mem_count++;
        if (a[31:30] != 2'b10)   // upper region never completes
        begin
          repeat (pick_delay())
          begin
            wait_cycle();
            mem_ready = 1'b0;
          end
          if (w)
            mem_model[a] = d;
          else if (!mem_model.exists(a))
            mem_model[a] = fill_word(a);
          mem_rdata  = w ? 32'h0 : mem_model[a];
          mem_rvalid = 1'b1;
        end
      end
    end
  end

  // compare every response with the queued expectation
  initial
  begin : compare
    exp_t  e;
    string n;
    forever
    begin
      wait_cycle();
      if (rsp_valid)
      begin
        if (exp_q.size() == 0)
          abort_run("a response arrived with no request outstanding");
        e = exp_q.pop_front();
        n = name_q.pop_front();
        check({n, " data"}, e.data, rsp_data);
        check({n, " fault"}, 32'(e.fault), 32'(rsp_fault));
        check({n, " error"}, 32'(e.error), 32'(rsp_error));
        check({n, " mem count"}, e.count, mem_count);
        if (!e.mem)
          check({n, " latency"}, 32'd2, cycle + 1 - e.acc);   // cpu takes it next edge
        rsp_seen++;
      end
    end
  end

  always @(posedge CPU_CLK)
  begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT_LIMIT)
      abort_run("timeout: the run did not finish within the cycle limit");
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial
  begin : stimulus
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] r;
    logic [15:0] vp1;
    logic [15:0] vp2;
    int          i;
    cpu_valid      = 1'b0;
    cpu_addr       = '0;
    cpu_we         = 1'b0;
    cpu_tlb_we     = 1'b0;
    cpu_force_miss = 1'b0;
    cpu_wdata      = '0;
    vmem_act       = 1'b0;
    wait_cycle();
    while (RST_CPU)
      wait_cycle();

    a1 = next_stim() & 32'h0FFF_FFFF;
    send("read miss", 1'b0, 1'b0, 1'b0, 1'b0, a1, 32'h0);
    send("read hit", 1'b0, 1'b0, 1'b0, 1'b0, a1, 32'h0);

    a2 = next_stim() & 32'h0FFF_FFFF;
    send("write through", 1'b1, 1'b0, 1'b0, 1'b0, a2, next_stim());
    send("write hit", 1'b0, 1'b0, 1'b0, 1'b0, a2, 32'h0);
    send("evict write", 1'b1, 1'b0, 1'b0, 1'b0, a2 ^ 32'h0010_0000, next_stim());
    send("evict miss", 1'b0, 1'b0, 1'b0, 1'b0, a2, 32'h0);
    send("force miss", 1'b0, 1'b0, 1'b1, 1'b0, a2, 32'h0);

    r   = next_stim();
    vp1 = r[31:16] & 16'h0FFF;
    vp2 = vp1 ^ 16'h0004;
    v1  = {vp1, r[15:8], r[23:16]};
    v2  = {vp2, r[15:8] + 8'd1, r[23:16] + 8'd7};
    send("tlb write 1", 1'b0, 1'b1, 1'b0, 1'b1, v1, {vp1 ^ 16'h0350, vp1});
    send("tlb write 2", 1'b0, 1'b1, 1'b0, 1'b1, v2, {vp2 ^ 16'h0350, vp2});
    send("translated read 1", 1'b0, 1'b0, 1'b0, 1'b1, v1, 32'h0);
    send("translated read 2", 1'b0, 1'b0, 1'b0, 1'b1, v2, 32'h0);
    send("translated hit", 1'b0, 1'b0, 1'b0, 1'b1, v1, 32'h0);
    send("tlb fault", 1'b0, 1'b0, 1'b0, 1'b1, {vp1 ^ 16'h0001, v1[15:0]}, 32'h0);
    send("untranslated", 1'b0, 1'b0, 1'b0, 1'b0, v1, 32'h0);

    r = 32'h8000_0000 | (next_stim() & 32'h3FFF_FFFF);
    send("watchdog error", 1'b0, 1'b0, 1'b0, 1'b0, r, 32'h0);
    send("after error", 1'b0, 1'b0, 1'b0, 1'b0, next_stim() & 32'h0FFF_FFFF, 32'h0);

    // small address set so hits, misses and evictions mix
    for (i = 0; i < 24; i++)
    begin
      r = next_stim();
      send("random", r[28], 1'b0, r[29] & r[30], 1'b0, (r >> 8) & 32'h0003_0003,
           next_stim());
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/snowball_cache_sva.sv */
`default_nettype none

module snowball_cache_sva
(
  input wire logic        CPU_CLK,
  input wire logic        RST_CPU,
  input wire logic        cpu_valid,
  input wire logic        cpu_ready,
  input wire logic        rsp_valid,
  input wire logic        rsp_fault,
  input wire logic        mem_valid,
  input wire logic        mem_ready,
  input wire logic        mem_we,
  input wire logic [31:0] mem_addr,
  input wire logic [31:0] mem_wdata
);

  logic outstanding;   // accepted, no response yet
  logic mem_seen;      // memory request since the last acceptance

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      outstanding <= 1'b0;
      mem_seen    <= 1'b0;
    end
    else
    begin
      if (cpu_valid && cpu_ready)
      begin
        outstanding <= 1'b1;
        mem_seen    <= 1'b0;
      end
      else if (rsp_valid)
        outstanding <= 1'b0;
      if (mem_valid)
        mem_seen <= 1'b1;
    end
  end

  // --------------------------------------------------
  // protocol properties
  // --------------------------------------------------
  mem_hold_a: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    mem_valid && !mem_ready |=>
      mem_valid && $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
    else $error("memory request changed before mem_ready");

  rsp_pulse_a: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    rsp_valid |=> !rsp_valid)
    else $error("rsp_valid longer than one cycle");

  busy_a: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    outstanding |-> !cpu_ready)
    else $error("cpu_ready high with a request outstanding");

  fault_quiet_a: assert property (@(posedge CPU_CLK) disable iff (RST_CPU)
    rsp_valid && rsp_fault |-> !mem_seen && !mem_valid)
    else $error("memory request issued for a faulting access");

endmodule

`default_nettype wire

/* sim/clk_gen.sv */
`default_nettype none

module clk_gen
#(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 8
)
(
  output logic CPU_CLK,
  output logic RST_CPU
);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #(PERIOD / 2) CPU_CLK = ~CPU_CLK;
  end

  // release just after an edge, like the other stimulus
  initial
  begin
    RST_CPU = 1'b1;
    repeat (RESET_CYCLES) @(posedge CPU_CLK);
    #1 RST_CPU = 1'b0;
  end

endmodule

`default_nettype wire

/* rtl/snowball_cache.sv */
`default_nettype none

module snowball_cache
#(
  parameter int TIMEOUT_CYCLES = 64
)
(
  input  logic        CPU_CLK,
  input  logic        RST_CPU,
  // cpu request and response
  input  logic        cpu_valid,
  output logic        cpu_ready,
  input  logic [31:0] cpu_addr,
  input  logic        cpu_we,
  input  logic        cpu_tlb_we,
  input  logic        cpu_force_miss,
  input  logic [31:0] cpu_wdata,
  input  logic        vmem_act,
  output logic        rsp_valid,
  output logic [31:0] rsp_data,
  output logic        rsp_fault,
  output logic        rsp_error,
  // memory
  output logic        mem_valid,
  input  logic        mem_ready,
  output logic        mem_we,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  input  logic        mem_rvalid,
  input  logic [31:0] mem_rdata
);

  logic timer_run;
  logic timer_expired;

  lookup_if lk_bus ();

  cache_lookup cache_lookup_i (
    .CPU_CLK (CPU_CLK),
    .lk      (lk_bus.lookup)
  );

  refill_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) refill_timer_i (
    .CPU_CLK (CPU_CLK),
    .RST_CPU (RST_CPU),
    .run     (timer_run),
    .expired (timer_expired)
  );

  cache_ctrl_fsm cache_ctrl_fsm_i (
    .CPU_CLK        (CPU_CLK),
    .RST_CPU        (RST_CPU),
    .cpu_valid      (cpu_valid),
    .cpu_ready      (cpu_ready),
    .cpu_addr       (cpu_addr),
    .cpu_we         (cpu_we),
    .cpu_tlb_we     (cpu_tlb_we),
    .cpu_force_miss (cpu_force_miss),
    .cpu_wdata      (cpu_wdata),
    .vmem_act       (vmem_act),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .rsp_fault      (rsp_fault),
    .rsp_error      (rsp_error),
    .mem_valid      (mem_valid),
    .mem_ready      (mem_ready),
    .mem_we         (mem_we),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_rvalid     (mem_rvalid),
    .mem_rdata      (mem_rdata),
    .lk             (lk_bus.ctrl),
    .timer_run      (timer_run),
    .timer_expired  (timer_expired)
  );

endmodule

`default_nettype wire

/* rtl/cache_ctrl_fsm.sv */
`default_nettype none

module cache_ctrl_fsm
(
  input  logic        CPU_CLK,
  input  logic        RST_CPU,
  // cpu side
  input  logic        cpu_valid,
  output logic        cpu_ready,
  input  logic [31:0] cpu_addr,
  input  logic        cpu_we,
  input  logic        cpu_tlb_we,
  input  logic        cpu_force_miss,
  input  logic [31:0] cpu_wdata,
  input  logic        vmem_act,
  output logic        rsp_valid,
  output logic [31:0] rsp_data,
  output logic        rsp_fault,
  output logic        rsp_error,
  // memory side
  output logic        mem_valid,
  input  logic        mem_ready,
  output logic        mem_we,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  input  logic        mem_rvalid,
  input  logic [31:0] mem_rdata,
  lookup_if.ctrl      lk,
  output logic        timer_run,
  input  logic        timer_expired
);

  localparam int IDX_W = cache_pkg::IDX_W;

  cache_pkg::ctrl_state_t state;
  logic [IDX_W-1:0]       sweep_idx;
  logic                   we_q;
  logic                   tlb_we_q;
  logic                   force_miss_q;
  logic                   vmem_q;
  logic [31:0]            wdata_q;
  logic                   fill_q;    // line write pending at response
  logic                   accept;
  logic                   mem_done;
  logic                   mem_abort;

  assign accept    = (state == cache_pkg::IDLE) && cpu_valid;
  assign cpu_ready = (state == cache_pkg::IDLE);
  assign rsp_valid = (state == cache_pkg::RESPOND);
  assign mem_valid = (state == cache_pkg::MEM_REQ);
  assign mem_we    = we_q;
  assign mem_wdata = wdata_q;
  assign timer_run = mem_valid || (state == cache_pkg::MEM_WAIT);

  // completion may come with the handshake or later
  assign mem_done  = mem_rvalid && ((state == cache_pkg::MEM_WAIT) || (mem_valid && mem_ready));
  assign mem_abort = timer_run && timer_expired && !mem_done;

  // --------------------------------------------------
  // lookup block controls
  // --------------------------------------------------
  assign lk.rd_en   = accept;   // arrays read on the accepting edge
  assign lk.rd_addr = cpu_addr;
  assign lk.vmem    = vmem_q;

  assign lk.tlb_we    = (state == cache_pkg::LOOKUP) && tlb_we_q;
  assign lk.tlb_idx   = lk.phys_addr[2*IDX_W-1:IDX_W];   // untouched by translation
  assign lk.tlb_wdata = cache_pkg::tlb_entry_t'(wdata_q);

  assign lk.line_we  = (state == cache_pkg::SWEEP) || ((state == cache_pkg::RESPOND) && fill_q);
  assign lk.line_idx = (state == cache_pkg::SWEEP) ? sweep_idx : mem_addr[IDX_W-1:0];

  always_comb
  begin
    lk.line_wdata = '0;   // invalid line during sweep
    if (state != cache_pkg::SWEEP)
    begin
      lk.line_wdata.valid = 1'b1;
      lk.line_wdata.tag   = mem_addr[31:IDX_W];
      lk.line_wdata.data  = rsp_data;
    end
  end

  // --------------------------------------------------
  // state and control flags
  // --------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU)
    begin
      state     <= cache_pkg::SWEEP;
      sweep_idx <= '0;
      fill_q    <= 1'b0;
      rsp_fault <= 1'b0;
      rsp_error <= 1'b0;
    end
    else
    begin
      case (state)
        cache_pkg::SWEEP:
        begin
          sweep_idx <= sweep_idx + 1'b1;
          if (sweep_idx == '1)
            state <= cache_pkg::IDLE;
        end
        cache_pkg::IDLE:
        begin
          if (accept)
            state <= cache_pkg::LOOKUP;
        end
        cache_pkg::LOOKUP:
        begin
          rsp_fault <= 1'b0;
          rsp_error <= 1'b0;
          if (tlb_we_q)
            state <= cache_pkg::RESPOND;
          else if (lk.fault)
          begin
            rsp_fault <= 1'b1;   // no memory traffic on a fault
            state     <= cache_pkg::RESPOND;
          end
          else if (!we_q && !force_miss_q && lk.hit)
            state <= cache_pkg::RESPOND;
          else
            state <= cache_pkg::MEM_REQ;
        end
        cache_pkg::MEM_REQ, cache_pkg::MEM_WAIT:
        begin
          if (mem_done)
          begin
            fill_q <= 1'b1;
            state  <= cache_pkg::RESPOND;
          end
          else if (mem_abort)
          begin
            rsp_error <= 1'b1;
            state     <= cache_pkg::RESPOND;
          end
          else if (mem_valid && mem_ready)
            state <= cache_pkg::MEM_WAIT;
        end
        cache_pkg::RESPOND:
        begin
          fill_q <= 1'b0;
          state  <= cache_pkg::IDLE;
        end
        default: state <= cache_pkg::IDLE;
      endcase
    end
  end

  // request capture and response data
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      we_q         <= cpu_we;
      tlb_we_q     <= cpu_tlb_we;
      force_miss_q <= cpu_force_miss;
      wdata_q      <= cpu_wdata;
      vmem_q       <= vmem_act;
    end
    if (state == cache_pkg::LOOKUP)
    begin
      mem_addr <= lk.phys_addr;
      if (tlb_we_q)
        rsp_data <= wdata_q;
      else if (lk.fault)
        rsp_data <= '0;
      else
        rsp_data <= lk.hit_data;   // overwritten later on a miss
    end
    if (mem_done)
      rsp_data <= we_q ? wdata_q : mem_rdata;
    else if (mem_abort)
      rsp_data <= '0;
  end

endmodule

`default_nettype wire

/* rtl/refill_timer.sv */
`default_nettype none

module refill_timer
#(
  parameter int TIMEOUT_CYCLES = 64
)
(
  input  logic CPU_CLK,
  input  logic RST_CPU,
  input  logic run,
  output logic expired
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  logic [CNT_W-1:0] count;

  // stays high until run drops
  assign expired = (count == CNT_W'(TIMEOUT_CYCLES));

  always_ff @(posedge CPU_CLK)
  begin
    if (RST_CPU || !run)
      count <= '0;
    else if (!expired)
      count <= count + 1'b1;   // saturate at the limit
  end

endmodule

`default_nettype wire

/* rtl/cache_lookup.sv */
`default_nettype none

module cache_lookup
(
  input  logic     CPU_CLK,
  lookup_if.lookup lk
);

  localparam int IDX_W = cache_pkg::IDX_W;

  cache_pkg::tlb_entry_t           tlb_rd;
  cache_pkg::line_t                line_rd;
  logic [31:0]                     addr_q;
  logic [cache_pkg::PAGE_W-1:0]    vpage;

  // --------------------------------------------------
  // arrays
  // --------------------------------------------------
  cache_ram #(
    .entry_t (cache_pkg::tlb_entry_t)
  ) tlb_ram_i (
    .CPU_CLK (CPU_CLK),
    .re      (lk.rd_en),
    .raddr   (lk.rd_addr[2*IDX_W-1:IDX_W]),  // bits 15:8
    .rdata   (tlb_rd),
    .we      (lk.tlb_we),
    .waddr   (lk.tlb_idx),
    .wdata   (lk.tlb_wdata)
  );

  cache_ram #(
    .entry_t (cache_pkg::line_t)
  ) line_ram_i (
    .CPU_CLK (CPU_CLK),
    .re      (lk.rd_en),
    .raddr   (lk.rd_addr[IDX_W-1:0]),
    .rdata   (line_rd),
    .we      (lk.line_we),
    .waddr   (lk.line_idx),
    .wdata   (lk.line_wdata)
  );

  // address lines up with the registered array outputs
  always_ff @(posedge CPU_CLK)
  begin
    if (lk.rd_en)
      addr_q <= lk.rd_addr;
  end

  assign vpage = addr_q[31:32-cache_pkg::PAGE_W];

  // --------------------------------------------------
  // translation and compare
  // --------------------------------------------------
  always_comb
  begin
    lk.phys_addr = addr_q;
    lk.fault     = 1'b0;
    if (lk.vmem)
    begin
      lk.phys_addr[31:32-cache_pkg::PAGE_W] = tlb_rd.ppage;
      lk.fault = (tlb_rd.vtag != vpage);   // entry belongs to another page
    end
  end

  assign lk.hit      = line_rd.valid && (line_rd.tag == lk.phys_addr[31:IDX_W]);
  assign lk.hit_data = line_rd.data;

endmodule

`default_nettype wire

/* rtl/cache_ram.sv */
`default_nettype none

module cache_ram
#(
  parameter type entry_t = logic [31:0]
)
(
  input  logic                        CPU_CLK,
  input  logic                        re,
  input  logic [cache_pkg::IDX_W-1:0] raddr,
  output entry_t                      rdata,
  input  logic                        we,
  input  logic [cache_pkg::IDX_W-1:0] waddr,
  input  entry_t                      wdata
);

  entry_t mem [0:(1 << cache_pkg::IDX_W)-1];

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
    if (re)
      rdata <= mem[raddr];   // holds while re is low
  end

endmodule

`default_nettype wire

/* rtl/lookup_if.sv */
`default_nettype none

interface lookup_if;

  // array read, one cycle ahead of the results
  logic                            rd_en;
  logic [31:0]                     rd_addr;
  logic                            vmem;

  logic                            line_we;
  logic [cache_pkg::IDX_W-1:0]     line_idx;
  cache_pkg::line_t                line_wdata;

  logic                            tlb_we;
  logic [cache_pkg::IDX_W-1:0]     tlb_idx;
  cache_pkg::tlb_entry_t           tlb_wdata;

  // valid the cycle after rd_en
  logic [31:0]                     phys_addr;
  logic                            fault;
  logic                            hit;
  logic [31:0]                     hit_data;

  modport ctrl (
    output rd_en, rd_addr, vmem, line_we, line_idx, line_wdata,
    output tlb_we, tlb_idx, tlb_wdata,
    input  phys_addr, fault, hit, hit_data
  );

  modport lookup (
    input  rd_en, rd_addr, vmem, line_we, line_idx, line_wdata,
    input  tlb_we, tlb_idx, tlb_wdata,
    output phys_addr, fault, hit, hit_data
  );

endinterface

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // --------------------------------------------------
  // address layout
  // --------------------------------------------------
  // [31:16] page, [15:8] tlb index, [7:0] line index
  localparam int IDX_W  = 8;
  localparam int PAGE_W = 16;
  localparam int TAG_W  = 24;   // physical address bits 31:8

  // physical page sits in the upper half of a tlb write
  typedef struct packed {
    logic [PAGE_W-1:0] ppage;
    logic [PAGE_W-1:0] vtag;
  } tlb_entry_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic [31:0]      data;
  } line_t;

  typedef enum logic [2:0] {
    SWEEP,      // invalidate all lines after reset
    IDLE,
    LOOKUP,
    MEM_REQ,
    MEM_WAIT,
    RESPOND
  } ctrl_state_t;

endpackage

`default_nettype wire
